/* design/core_perf_pkg.sv */
/*
 * Shared constants for the core memory-traffic performance monitor.
 * Lane count, counter and bus widths, and the configuration register
 * addresses of the base registers. Every RTL block imports this package.
 */
package core_perf_pkg;

    // Data-cache request lanes observed by the monitor
    localparam int NUM_DCACHE_LANES = 4;

    // Every exported performance counter has this width
    localparam int PERF_CTR_BITS = 32;

    // Outstanding reads on one data-cache lane
    localparam int LANE_PENDING_BITS = 8;

    // Sum of all lane counts, with headroom for the lane adds
    localparam int TOTAL_PENDING_BITS = LANE_PENDING_BITS + $clog2(NUM_DCACHE_LANES);

    // Per-cycle popcount over the lanes, 0 through NUM_DCACHE_LANES
    localparam int LANE_SUM_BITS = $clog2(NUM_DCACHE_LANES + 1);

    // Configuration bus
    localparam int DCR_ADDR_WIDTH = 12;
    localparam int DCR_DATA_WIDTH = 32;

    // Base register addresses on the configuration bus
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_STARTUP_ADDR = 12'h001;
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_STARTUP_ARG  = 12'h003;

endpackage

/* design/dcr_base_regs.sv */
/*
 * Base configuration registers of the core.
 * Captures configuration-bus writes into the startup address and the
 * startup argument. A write shows on the outputs one cycle later; writes
 * to any other address are dropped.
 */
`timescale 1ns/1ps

module dcr_base_regs import core_perf_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      dcr_write_valid,
    input  logic [DCR_ADDR_WIDTH-1:0] dcr_write_addr,
    input  logic [DCR_DATA_WIDTH-1:0] dcr_write_data,

    output logic [DCR_DATA_WIDTH-1:0] startup_addr,
    output logic [DCR_DATA_WIDTH-1:0] startup_arg
);

    logic [DCR_DATA_WIDTH-1:0] startup_addr_q;
    logic [DCR_DATA_WIDTH-1:0] startup_arg_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            startup_addr_q <= '0;
            startup_arg_q  <= '0;
        end else if (dcr_write_valid) begin
            case (dcr_write_addr)
                DCR_STARTUP_ADDR: startup_addr_q <= dcr_write_data;
                DCR_STARTUP_ARG:  startup_arg_q  <= dcr_write_data;
                default: begin
                    // Unmapped address, nothing to load
                end
            endcase
        end
    end

    assign startup_addr = startup_addr_q;
    assign startup_arg  = startup_arg_q;

endmodule

/* design/dcache_lane_monitor.sv */
/*
 * Observer for one data-cache request lane.
 * Forms the read, write and response fire strobes of the lane and keeps
 * the lane's count of outstanding reads. Instantiated once per lane.
 */
`timescale 1ns/1ps

module dcache_lane_monitor import core_perf_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         req_valid,
    input  logic                         req_rw,
    input  logic                         req_ready,
    input  logic                         rsp_valid,
    input  logic                         rsp_ready,

    output logic                         rd_fire,
    output logic                         wr_fire,
    output logic                         rsp_fire,
    output logic [LANE_PENDING_BITS-1:0] pending
);

    logic                         req_fire;
    logic [LANE_PENDING_BITS-1:0] pending_q;

    // A transfer happens only with valid and ready both high
    assign req_fire = req_valid & req_ready;
    assign rd_fire  = req_fire & ~req_rw;
    assign wr_fire  = req_fire & req_rw;
    assign rsp_fire = rsp_valid & rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            case ({rd_fire, rsp_fire})
                2'b10:   pending_q <= pending_q + 1'b1;
                2'b01:   pending_q <= pending_q - 1'b1;
                // Read and response together cancel out
                default: pending_q <= pending_q;
            endcase
        end
    end

    assign pending = pending_q;

endmodule

/* design/icache_monitor.sv */
/*
 * Instruction-cache traffic monitor.
 * Counts fired fetch requests and tracks outstanding fetches. Each cycle
 * the registered outstanding count is added to the fetch latency total,
 * so a fetch answered k cycles after it fired adds exactly k.
 */
`timescale 1ns/1ps

module icache_monitor import core_perf_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     req_valid,
    input  logic                     req_ready,
    input  logic                     rsp_valid,
    input  logic                     rsp_ready,

    output logic [PERF_CTR_BITS-1:0] ifetches,
    output logic [PERF_CTR_BITS-1:0] ifetch_latency
);

    logic                     req_fire;
    logic                     rsp_fire;
    logic [PERF_CTR_BITS-1:0] pending_q;
    logic [PERF_CTR_BITS-1:0] ifetches_q;
    logic [PERF_CTR_BITS-1:0] latency_q;

    assign req_fire = req_valid & req_ready;
    assign rsp_fire = rsp_valid & rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            case ({req_fire, rsp_fire})
                2'b10:   pending_q <= pending_q + 1'b1;
                2'b01:   pending_q <= pending_q - 1'b1;
                default: pending_q <= pending_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches_q <= '0;
            latency_q  <= '0;
        end else begin
            ifetches_q <= ifetches_q + PERF_CTR_BITS'(req_fire);
            // Old outstanding count, one cycle per fetch in flight
            latency_q  <= latency_q + pending_q;
        end
    end

    assign ifetches       = ifetches_q;
    assign ifetch_latency = latency_q;

endmodule

/* design/dcache_perf_aggregator.sv */
/*
 * Data-cache counter block fed by the per-lane monitors.
 * Popcounts the read and write strobes into the load and store counters
 * and adds the summed lane outstanding counts to the load latency total
 * every cycle. Responses reach it through the lane pending counts.
 */
`timescale 1ns/1ps

module dcache_perf_aggregator import core_perf_pkg::*; (
    input  logic                                               clk,
    input  logic                                               reset,

    input  logic [NUM_DCACHE_LANES-1:0]                        rd_fire,
    input  logic [NUM_DCACHE_LANES-1:0]                        wr_fire,
    input  logic [NUM_DCACHE_LANES-1:0][LANE_PENDING_BITS-1:0] lane_pending,

    output logic [PERF_CTR_BITS-1:0]                           loads,
    output logic [PERF_CTR_BITS-1:0]                           stores,
    output logic [PERF_CTR_BITS-1:0]                           load_latency
);

    logic [LANE_SUM_BITS-1:0]      rd_per_cycle;
    logic [LANE_SUM_BITS-1:0]      wr_per_cycle;
    logic [TOTAL_PENDING_BITS-1:0] total_pending;

    logic [PERF_CTR_BITS-1:0]      loads_q;
    logic [PERF_CTR_BITS-1:0]      stores_q;
    logic [PERF_CTR_BITS-1:0]      latency_q;

    function automatic logic [LANE_SUM_BITS-1:0] lane_popcount(
        input logic [NUM_DCACHE_LANES-1:0] bits
    );
        logic [LANE_SUM_BITS-1:0] count;
        count = '0;
        for (int i = 0; i < NUM_DCACHE_LANES; i++) begin
            count = count + LANE_SUM_BITS'(bits[i]);
        end
        return count;
    endfunction

    assign rd_per_cycle = lane_popcount(rd_fire);
    assign wr_per_cycle = lane_popcount(wr_fire);

    // Reads in flight across all lanes
    always_comb begin
        total_pending = '0;
        for (int i = 0; i < NUM_DCACHE_LANES; i++) begin
            total_pending = total_pending + TOTAL_PENDING_BITS'(lane_pending[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loads_q   <= '0;
            stores_q  <= '0;
            latency_q <= '0;
        end else begin
            loads_q   <= loads_q + PERF_CTR_BITS'(rd_per_cycle);
            stores_q  <= stores_q + PERF_CTR_BITS'(wr_per_cycle);
            latency_q <= latency_q + PERF_CTR_BITS'(total_pending);
        end
    end

    assign loads        = loads_q;
    assign stores       = stores_q;
    assign load_latency = latency_q;

endmodule

/* design/core_mem_monitor.sv */
/*
 * Top level of the core memory-traffic performance monitor.
 * Holds the base configuration registers and observes the instruction
 * and data cache buses without driving them. Every input event reaches
 * the outputs one cycle later.
 */
`timescale 1ns/1ps

module core_mem_monitor import core_perf_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,

    // Configuration bus
    input  logic                        dcr_write_valid,
    input  logic [DCR_ADDR_WIDTH-1:0]   dcr_write_addr,
    input  logic [DCR_DATA_WIDTH-1:0]   dcr_write_data,

    // Instruction cache
    input  logic                        icache_req_valid,
    input  logic                        icache_req_ready,
    input  logic                        icache_rsp_valid,
    input  logic                        icache_rsp_ready,

    // Data cache, one bit per lane
    input  logic [NUM_DCACHE_LANES-1:0] dcache_req_valid,
    input  logic [NUM_DCACHE_LANES-1:0] dcache_req_rw,
    input  logic [NUM_DCACHE_LANES-1:0] dcache_req_ready,
    input  logic [NUM_DCACHE_LANES-1:0] dcache_rsp_valid,
    input  logic [NUM_DCACHE_LANES-1:0] dcache_rsp_ready,

    output logic [DCR_DATA_WIDTH-1:0]   startup_addr,
    output logic [DCR_DATA_WIDTH-1:0]   startup_arg,
    output logic [PERF_CTR_BITS-1:0]    ifetches,
    output logic [PERF_CTR_BITS-1:0]    ifetch_latency,
    output logic [PERF_CTR_BITS-1:0]    loads,
    output logic [PERF_CTR_BITS-1:0]    stores,
    output logic [PERF_CTR_BITS-1:0]    load_latency
);

    logic [NUM_DCACHE_LANES-1:0]                        dcache_rd_fire;
    logic [NUM_DCACHE_LANES-1:0]                        dcache_wr_fire;
    logic [NUM_DCACHE_LANES-1:0][LANE_PENDING_BITS-1:0] lane_pending;

    dcr_base_regs i_dcr_base_regs (
        .clk             (clk),
        .reset           (reset),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .startup_addr    (startup_addr),
        .startup_arg     (startup_arg)
    );

    icache_monitor i_icache_monitor (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (icache_req_valid),
        .req_ready      (icache_req_ready),
        .rsp_valid      (icache_rsp_valid),
        .rsp_ready      (icache_rsp_ready),
        .ifetches       (ifetches),
        .ifetch_latency (ifetch_latency)
    );

    // One observer per data-cache lane
    // Responses reach the aggregator only through the lane pending counts
    for (genvar i = 0; i < NUM_DCACHE_LANES; i++) begin : g_lane
        dcache_lane_monitor i_dcache_lane_monitor (
            .clk       (clk),
            .reset     (reset),
            .req_valid (dcache_req_valid[i]),
            .req_rw    (dcache_req_rw[i]),
            .req_ready (dcache_req_ready[i]),
            .rsp_valid (dcache_rsp_valid[i]),
            .rsp_ready (dcache_rsp_ready[i]),
            .rd_fire   (dcache_rd_fire[i]),
            .wr_fire   (dcache_wr_fire[i]),
            .rsp_fire  (),
            .pending   (lane_pending[i])
        );
    end

    dcache_perf_aggregator i_dcache_perf_aggregator (
        .clk          (clk),
        .reset        (reset),
        .rd_fire      (dcache_rd_fire),
        .wr_fire      (dcache_wr_fire),
        .lane_pending (lane_pending),
        .loads        (loads),
        .stores       (stores),
        .load_latency (load_latency)
    );

endmodule

/* test/core_mem_monitor_tb.sv */
/*
 * Testbench for the core memory-traffic monitor.
 * Replays test/mem_monitor_tests.txt from the project root. S lines drive
 * every DUT input for one cycle, C lines hold the expected values of all
 * seven outputs, sampled just before the edge that takes the last S line.
 */
`timescale 1ns/1ps

module core_mem_monitor_tb import core_perf_pkg::*; ();

    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    RESET_CYCLES = 16;
    localparam string TEST_FILE    = "test/mem_monitor_tests.txt";

    logic                        clk;
    logic                        reset;

    logic                        dcr_write_valid;
    logic [DCR_ADDR_WIDTH-1:0]   dcr_write_addr;
    logic [DCR_DATA_WIDTH-1:0]   dcr_write_data;

    logic                        icache_req_valid;
    logic                        icache_req_ready;
    logic                        icache_rsp_valid;
    logic                        icache_rsp_ready;

    logic [NUM_DCACHE_LANES-1:0] dcache_req_valid;
    logic [NUM_DCACHE_LANES-1:0] dcache_req_rw;
    logic [NUM_DCACHE_LANES-1:0] dcache_req_ready;
    logic [NUM_DCACHE_LANES-1:0] dcache_rsp_valid;
    logic [NUM_DCACHE_LANES-1:0] dcache_rsp_ready;

    logic [DCR_DATA_WIDTH-1:0]   startup_addr;
    logic [DCR_DATA_WIDTH-1:0]   startup_arg;
    logic [PERF_CTR_BITS-1:0]    ifetches;
    logic [PERF_CTR_BITS-1:0]    ifetch_latency;
    logic [PERF_CTR_BITS-1:0]    loads;
    logic [PERF_CTR_BITS-1:0]    stores;
    logic [PERF_CTR_BITS-1:0]    load_latency;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    core_mem_monitor i_core_mem_monitor (
        .clk              (clk),
        .reset            (reset),
        .dcr_write_valid  (dcr_write_valid),
        .dcr_write_addr   (dcr_write_addr),
        .dcr_write_data   (dcr_write_data),
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .startup_addr     (startup_addr),
        .startup_arg      (startup_arg),
        .ifetches         (ifetches),
        .ifetch_latency   (ifetch_latency),
        .loads            (loads),
        .stores           (stores),
        .load_latency     (load_latency)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Run limit, known once the data file has been measured
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [PERF_CTR_BITS-1:0] expected,
                               input logic [PERF_CTR_BITS-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs(input logic [PERF_CTR_BITS-1:0] exp_addr,
                                 input logic [PERF_CTR_BITS-1:0] exp_arg,
                                 input logic [PERF_CTR_BITS-1:0] exp_ifetches,
                                 input logic [PERF_CTR_BITS-1:0] exp_ifetch_lat,
                                 input logic [PERF_CTR_BITS-1:0] exp_loads,
                                 input logic [PERF_CTR_BITS-1:0] exp_stores,
                                 input logic [PERF_CTR_BITS-1:0] exp_load_lat);
        check_value("startup_addr", exp_addr, startup_addr);
        check_value("startup_arg", exp_arg, startup_arg);
        check_value("ifetches", exp_ifetches, ifetches);
        check_value("ifetch_latency", exp_ifetch_lat, ifetch_latency);
        check_value("loads", exp_loads, loads);
        check_value("stores", exp_stores, stores);
        check_value("load_latency", exp_load_lat, load_latency);
    endtask

    initial begin
        int                          fd;
        int                          code;
        int                          line_count;
        logic                        done;
        time                         drive_time;
        time                         sample_time;
        logic [8*8-1:0]              tag;
        logic [8*256-1:0]            rest;
        logic                        dv;
        logic [DCR_ADDR_WIDTH-1:0]   da;
        logic [DCR_DATA_WIDTH-1:0]   dd;
        logic                        iqv, iqr, isv, isr;
        logic [NUM_DCACHE_LANES-1:0] dqv, drw, dqr, dsv, dsr;
        logic [PERF_CTR_BITS-1:0]    e_addr, e_arg, e_ifetch, e_ifetch_lat;
        logic [PERF_CTR_BITS-1:0]    e_loads, e_stores, e_load_lat;

        reset            = 1'b1;
        dcr_write_valid  = 1'b0;
        dcr_write_addr   = '0;
        dcr_write_data   = '0;
        icache_req_valid = 1'b0;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_ready = 1'b0;
        dcache_req_valid = '0;
        dcache_req_rw    = '0;
        dcache_req_ready = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;

        // Measure the file first to size the run limit
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the data file %s", TEST_FILE);
            error_count++;
        end else begin
            line_count = 0;
            while (!$feof(fd)) begin
                code = $fgets(rest, fd);
                if (code > 0) begin
                    line_count++;
                end
            end
            $fclose(fd);
            cycle_limit = 2 * line_count + 64;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        drive_time = $time;

        if (cycle_limit > 0) begin
            fd = $fopen(TEST_FILE, "r");
            done = 1'b0;
            while (!done) begin
                tag = '0;
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "S") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                   dv, da, dd, iqv, iqr, isv, isr, dqv, drw, dqr, dsv, dsr);
                    if (code != 12) begin
                        $display("Malformed stimulus line in %s", TEST_FILE);
                        error_count++;
                        done = 1'b1;
                    end else begin
                        @(posedge clk);
                        #(DRIVE_DELAY);
                        dcr_write_valid  = dv;
                        dcr_write_addr   = da;
                        dcr_write_data   = dd;
                        icache_req_valid = iqv;
                        icache_req_ready = iqr;
                        icache_rsp_valid = isv;
                        icache_rsp_ready = isr;
                        dcache_req_valid = dqv;
                        dcache_req_rw    = drw;
                        dcache_req_ready = dqr;
                        dcache_rsp_valid = dsv;
                        dcache_rsp_ready = dsr;
                        drive_time = $time;
                    end
                end else if (tag == "C") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h", e_addr, e_arg, e_ifetch,
                                   e_ifetch_lat, e_loads, e_stores, e_load_lat);
                    if (code != 7) begin
                        $display("Malformed checkpoint line in %s", TEST_FILE);
                        error_count++;
                        done = 1'b1;
                    end else begin
                        // Just before the next rising edge
                        sample_time = drive_time + CLK_PERIOD - DRIVE_DELAY - 1;
                        if ($time < sample_time) begin
                            #(sample_time - $time);
                        end
                        check_outputs(e_addr, e_arg, e_ifetch, e_ifetch_lat,
                                      e_loads, e_stores, e_load_lat);
                    end
                end else begin
                    $display("Unknown line type in %s", TEST_FILE);
                    error_count++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
            if (check_count == 0) begin
                $display("The data file holds no checkpoint lines");
                error_count++;
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* test/mem_monitor_tests.txt */
# S dcr_valid dcr_addr dcr_data ic_req_valid ic_req_ready ic_rsp_valid ic_rsp_ready dc_req_valid dc_req_rw dc_req_ready dc_rsp_valid dc_rsp_ready
# C startup_addr startup_arg ifetches ifetch_latency loads stores load_latency (all hex)
C 00000000 00000000 0 0 0 0 0
# Base registers, one cycle after the write
S 1 001 12345678 0 0 0 0 0 0 0 0 0
C 00000000 00000000 0 0 0 0 0
S 1 003 cafef00d 0 0 0 0 0 0 0 0 0
C 12345678 00000000 0 0 0 0 0
S 1 002 deadbeef 0 0 0 0 0 0 0 0 0
S 0 001 ffffffff 0 0 0 0 0 0 0 0 0
S 0 000 00000000 0 0 0 0 0 0 0 0 0
C 12345678 cafef00d 0 0 0 0 0
# Instruction fetches, held request, overlap, request and response together
S 0 000 00000000 1 0 0 0 0 0 0 0 0
S 0 000 00000000 1 1 0 0 0 0 0 0 0
S 0 000 00000000 0 0 0 0 0 0 0 0 0
S 0 000 00000000 0 0 1 1 0 0 0 0 0
S 0 000 00000000 0 0 0 0 0 0 0 0 0
C 12345678 cafef00d 1 2 0 0 0
S 0 000 00000000 1 1 0 0 0 0 0 0 0
S 0 000 00000000 1 1 0 0 0 0 0 0 0
S 0 000 00000000 0 0 1 1 0 0 0 0 0
S 0 000 00000000 0 0 0 0 0 0 0 0 0
S 0 000 00000000 0 0 1 1 0 0 0 0 0
S 0 000 00000000 1 1 0 0 0 0 0 0 0
S 0 000 00000000 1 1 1 1 0 0 0 0 0
S 0 000 00000000 0 0 1 1 0 0 0 0 0
S 0 000 00000000 1 0 1 0 0 0 0 0 0
S 0 000 00000000 0 0 0 0 0 0 0 0 0
C 12345678 cafef00d 5 9 0 0 0
# Loads and stores across lanes
S 0 000 00000000 0 0 0 0 f a f 0 0
S 0 000 00000000 0 0 0 0 3 3 3 5 5
S 0 000 00000000 0 0 0 0 f 0 7 0 0
S 0 000 00000000 0 0 0 0 0 0 0 7 3
S 0 000 00000000 0 0 0 0 0 0 0 4 4
S 0 000 00000000 0 0 0 0 0 0 0 0 0
C 12345678 cafef00d 5 9 5 4 6
# Overlapping reads, held response, read and response on one lane
S 0 000 00000000 0 0 0 0 1 0 1 0 0
S 0 000 00000000 0 0 0 0 2 0 2 0 0
S 0 000 00000000 0 0 0 0 8 0 0 1 0
S 0 000 00000000 0 0 0 0 8 0 8 1 1
S 0 000 00000000 0 0 0 0 2 0 2 2 2
S 0 000 00000000 0 0 0 0 0 0 0 a a
S 0 000 00000000 0 0 0 0 0 0 0 0 0
C 12345678 cafef00d 5 9 9 4 f
# Everything at once
S 1 001 00000080 1 1 0 0 f f f 0 0
S 0 000 00000000 0 0 1 1 f 0 f 0 0
S 0 000 00000000 0 0 0 0 0 0 0 f f
S 0 000 00000000 0 0 0 0 0 0 0 0 0
C 00000080 cafef00d 6 a d 8 13

/* verilog.f */
design/core_perf_pkg.sv
design/dcr_base_regs.sv
design/dcache_lane_monitor.sv
design/icache_monitor.sv
design/dcache_perf_aggregator.sv
design/core_mem_monitor.sv
test/core_mem_monitor_tb.sv

/* Makefile */
# Verilator build and run of the core memory-traffic monitor testbench

TOP := core_mem_monitor_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, pass on >>> PASS"
	@echo "  clean  remove the build folder"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--Mdir build --top-module $(TOP) -f verilog.f
	./build/V$(TOP) | tee /dev/stderr | grep -qxF '>>> PASS'

clean:
	rm -rf build
